// File: rtl/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

	// RGB444, red in the top nibble
	typedef logic [11:0] color_t;

	// Palette index, low nibble zero is transparent
	typedef logic [7:0] color_index_t;

	typedef logic [11:0] apb_addr_t;
	typedef logic [15:0] apb_data_t;

	// Pixel coordinate or raster counter
	typedef logic [9:0] coord_t;

	// Register map (word addresses)
	localparam apb_addr_t REG_FRAME_COUNT = 12'hF00;
	localparam apb_addr_t REG_DISPLAY_Y   = 12'hF01;
	localparam apb_addr_t REG_VIDEO_MODE  = 12'hF02;
	localparam apb_addr_t REG_BG_COLOR    = 12'hF03;

	// Palette occupies E00 to EFF, write only
	localparam apb_addr_t PALETTE_BASE    = 12'hE00;

	// Default 640x480 raster
	localparam int H_ACTIVE_DEF = 640;
	localparam int H_FRONT_DEF  = 16;
	localparam int H_SYNC_DEF   = 96;
	localparam int H_BACK_DEF   = 48;

	localparam int V_ACTIVE_DEF = 480;
	localparam int V_FRONT_DEF  = 10;
	localparam int V_SYNC_DEF   = 2;
	localparam int V_BACK_DEF   = 33;

endpackage

`default_nettype wire

// File: rtl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
	parameter int H_ACTIVE = gfx_pkg::H_ACTIVE_DEF,
	parameter int H_FRONT  = gfx_pkg::H_FRONT_DEF,
	parameter int H_SYNC   = gfx_pkg::H_SYNC_DEF,
	parameter int H_BACK   = gfx_pkg::H_BACK_DEF,
	parameter int V_ACTIVE = gfx_pkg::V_ACTIVE_DEF,
	parameter int V_FRONT  = gfx_pkg::V_FRONT_DEF,
	parameter int V_SYNC   = gfx_pkg::V_SYNC_DEF,
	parameter int V_BACK   = gfx_pkg::V_BACK_DEF
)
(
	input  wire            CLK,
	input  wire            RSTb,
	input  wire            video_mode,
	output gfx_pkg::coord_t pixel_x,
	output gfx_pkg::coord_t pixel_y,
	output logic           de,
	output logic           hs,
	output logic           vs,
	output logic           irq_hsync,
	output logic           irq_vsync,
	output logic           frame_tick
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam gfx_pkg::coord_t H_LAST     = gfx_pkg::coord_t'(H_TOTAL - 1);
	localparam gfx_pkg::coord_t V_LAST     = gfx_pkg::coord_t'(V_TOTAL - 1);
	localparam gfx_pkg::coord_t H_DE_END   = gfx_pkg::coord_t'(H_ACTIVE);
	localparam gfx_pkg::coord_t V_DE_END   = gfx_pkg::coord_t'(V_ACTIVE);
	localparam gfx_pkg::coord_t HS_START   = gfx_pkg::coord_t'(H_ACTIVE + H_FRONT);
	localparam gfx_pkg::coord_t HS_END     = gfx_pkg::coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam gfx_pkg::coord_t VS_START   = gfx_pkg::coord_t'(V_ACTIVE + V_FRONT);
	localparam gfx_pkg::coord_t VS_END     = gfx_pkg::coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

	gfx_pkg::coord_t hcount;
	gfx_pkg::coord_t vcount;

	logic h_last;
	logic v_last;

	assign h_last = (hcount == H_LAST);
	assign v_last = (vcount == V_LAST);

	// Raster counters, vcount steps on each line wrap
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			hcount <= '0;
			vcount <= '0;
		end
		else if (h_last)
		begin
			hcount <= '0;
			if (v_last)
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;
		end
		else
		begin
			hcount <= hcount + 1'b1;
		end
	end

	assign de = (hcount < H_DE_END) && (vcount < V_DE_END);

	// Sync pulses are active low
	assign hs = !((hcount >= HS_START) && (hcount < HS_END));
	assign vs = !((vcount >= VS_START) && (vcount < VS_END));

	// Interrupts on the leading edge of each sync
	assign irq_hsync  = (hcount == HS_START);
	assign irq_vsync  = (vcount == VS_START) && (hcount == '0);
	assign frame_tick = (hcount == '0) && (vcount == '0);

	// Half resolution repeats each pixel and each line
	assign pixel_x = video_mode ? (hcount >> 1) : hcount;
	assign pixel_y = video_mode ? (vcount >> 1) : vcount;

	a_hsync_single: assert property (@(posedge CLK) disable iff (!RSTb)
		irq_hsync |=> !irq_hsync);

endmodule

`default_nettype wire

// File: rtl/gfx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_regs (
	input  wire                  CLK,
	input  wire                  RSTb,

	input  wire                  psel,
	input  wire                  penable,
	input  wire                  pwrite,
	input  wire gfx_pkg::apb_addr_t paddr,
	input  wire gfx_pkg::apb_data_t pwdata,
	output gfx_pkg::apb_data_t   prdata,
	output logic                 pready,
	output logic                 pslverr,

	input  wire                  frame_tick,
	input  wire gfx_pkg::coord_t pixel_y,

	output logic                 video_mode,
	output gfx_pkg::color_t      bg_color,
	output logic                 pal_we,
	output gfx_pkg::color_index_t pal_waddr,
	output gfx_pkg::color_t      pal_wdata
);

	logic access;

	logic hit_frame;
	logic hit_y;
	logic hit_mode;
	logic hit_bg;
	logic hit_pal;
	logic mapped;
	logic bad_access;
	logic wr_ok;

	gfx_pkg::apb_data_t frame_count;
	gfx_pkg::apb_data_t rd_data;

	// Set after the tick that follows reset release
	logic tick_seen;

	assign access = psel && penable;

	// Address decode
	assign hit_frame = (paddr == gfx_pkg::REG_FRAME_COUNT);
	assign hit_y     = (paddr == gfx_pkg::REG_DISPLAY_Y);
	assign hit_mode  = (paddr == gfx_pkg::REG_VIDEO_MODE);
	assign hit_bg    = (paddr == gfx_pkg::REG_BG_COLOR);
	assign hit_pal   = (paddr[11:8] == gfx_pkg::PALETTE_BASE[11:8]);
	assign mapped    = hit_frame || hit_y || hit_mode || hit_bg || hit_pal;

	// Read-only status written, or write-only palette read
	assign bad_access = !mapped
		|| (pwrite && (hit_frame || hit_y))
		|| (!pwrite && hit_pal);

	assign pready  = access;
	assign pslverr = access && bad_access;

	assign wr_ok = access && pwrite && !bad_access;

	// Control registers
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			video_mode <= 1'b0;
			bg_color   <= '0;
		end
		else if (wr_ok)
		begin
			if (hit_mode)
				video_mode <= pwdata[0];
			if (hit_bg)
				bg_color <= pwdata[11:0];
		end
	end

	// Frame counter skips the first tick after reset
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			frame_count <= '0;
			tick_seen   <= 1'b0;
		end
		else if (frame_tick)
		begin
			tick_seen <= 1'b1;
			if (tick_seen)
				frame_count <= frame_count + 1'b1;
		end
	end

	// Palette strobe lands on the edge ending the access phase
	assign pal_we    = wr_ok && hit_pal;
	assign pal_waddr = paddr[7:0];
	assign pal_wdata = pwdata[11:0];

	// Readback mux
	always_comb
	begin
		rd_data = '0;
		if (hit_frame)
			rd_data = frame_count;
		else if (hit_y)
			rd_data = gfx_pkg::apb_data_t'(pixel_y);
		else if (hit_mode)
			rd_data = gfx_pkg::apb_data_t'(video_mode);
		else if (hit_bg)
			rd_data = gfx_pkg::apb_data_t'(bg_color);
	end

	assign prdata = (access && !pwrite) ? rd_data : '0;

	a_penable_needs_psel: assert property (@(posedge CLK) disable iff (!RSTb)
		penable |-> psel);

	a_err_in_access: assert property (@(posedge CLK) disable iff (!RSTb)
		pslverr |-> pready);

endmodule

`default_nettype wire

// File: rtl/palette_ram.sv
`timescale 1ns/1ps
`default_nettype none

module palette_ram (
	input  wire                         CLK,
	input  wire                         we,
	input  wire gfx_pkg::color_index_t  waddr,
	input  wire gfx_pkg::color_index_t  raddr,
	input  wire gfx_pkg::color_t        wdata,
	output gfx_pkg::color_t             rdata
);

	gfx_pkg::color_t mem [0:255];

	// Write port
	always_ff @(posedge CLK)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read, old data on a same-entry collision
	always_ff @(posedge CLK)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: rtl/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
	input  wire                         CLK,
	input  wire                         RSTb,
	input  wire gfx_pkg::color_index_t  sprite_index,
	input  wire gfx_pkg::color_index_t  bg_index,
	input  wire                         de,
	input  wire                         hs,
	input  wire                         vs,
	input  wire gfx_pkg::color_t        bg_color,
	input  wire gfx_pkg::color_t        pal_rdata,
	output gfx_pkg::color_index_t       pal_raddr,
	output logic [3:0]                  red,
	output logic [3:0]                  green,
	output logic [3:0]                  blue,
	output logic                        hs_out,
	output logic                        vs_out
);

	logic sprite_hit;
	logic transparent;

	// Stage 1 state
	logic trans_d;
	logic de_d;
	logic hs_d;
	logic vs_d;

	// Stage 2 state
	gfx_pkg::color_t pix_q;

	// Sprite wins unless its low nibble is clear
	assign sprite_hit  = (sprite_index[3:0] != 4'h0);
	assign pal_raddr   = sprite_hit ? sprite_index : bg_index;
	assign transparent = (pal_raddr[3:0] == 4'h0);

	// Stage 1, aligned with the palette read
	always_ff @(posedge CLK)
	begin
		trans_d <= transparent;
		if (!RSTb)
		begin
			de_d <= 1'b0;
			hs_d <= 1'b1;
			vs_d <= 1'b1;
		end
		else
		begin
			de_d <= de;
			hs_d <= hs;
			vs_d <= vs;
		end
	end

	// Stage 2, background substitution and blanking
	always_ff @(posedge CLK)
	begin
		if (!RSTb)
		begin
			pix_q  <= '0;
			hs_out <= 1'b1;
			vs_out <= 1'b1;
		end
		else
		begin
			if (!de_d)
				pix_q <= '0;
			else if (trans_d)
				pix_q <= bg_color;
			else
				pix_q <= pal_rdata;
			hs_out <= hs_d;
			vs_out <= vs_d;
		end
	end

	assign red   = pix_q[11:8];
	assign green = pix_q[7:4];
	assign blue  = pix_q[3:0];

endmodule

`default_nettype wire

// File: rtl/gfx_top.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_top #(
	parameter int H_ACTIVE = gfx_pkg::H_ACTIVE_DEF,
	parameter int H_FRONT  = gfx_pkg::H_FRONT_DEF,
	parameter int H_SYNC   = gfx_pkg::H_SYNC_DEF,
	parameter int H_BACK   = gfx_pkg::H_BACK_DEF,
	parameter int V_ACTIVE = gfx_pkg::V_ACTIVE_DEF,
	parameter int V_FRONT  = gfx_pkg::V_FRONT_DEF,
	parameter int V_SYNC   = gfx_pkg::V_SYNC_DEF,
	parameter int V_BACK   = gfx_pkg::V_BACK_DEF
)
(
	input  wire                         CLK,
	input  wire                         RSTb,

	// APB slave
	input  wire                         psel,
	input  wire                         penable,
	input  wire                         pwrite,
	input  wire gfx_pkg::apb_addr_t     paddr,
	input  wire gfx_pkg::apb_data_t     pwdata,
	output gfx_pkg::apb_data_t          prdata,
	output logic                        pready,
	output logic                        pslverr,

	// External sprite and background layers
	output gfx_pkg::coord_t             pixel_x,
	output gfx_pkg::coord_t             pixel_y,
	input  wire gfx_pkg::color_index_t  sprite_index,
	input  wire gfx_pkg::color_index_t  bg_index,

	// Video out
	output logic [3:0]                  red,
	output logic [3:0]                  green,
	output logic [3:0]                  blue,
	output logic                        hs,
	output logic                        vs,
	output logic                        de,
	output logic                        irq_hsync,
	output logic                        irq_vsync
);

	logic                   video_mode;
	logic                   frame_tick;
	logic                   tim_hs;
	logic                   tim_vs;
	logic                   pal_we;
	gfx_pkg::color_t        bg_color;
	gfx_pkg::color_t        pal_wdata;
	gfx_pkg::color_t        pal_rdata;
	gfx_pkg::color_index_t  pal_waddr;
	gfx_pkg::color_index_t  pal_raddr;

	gfx_regs regs0 (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.frame_tick (frame_tick),
		.pixel_y    (pixel_y),
		.video_mode (video_mode),
		.bg_color   (bg_color),
		.pal_we     (pal_we),
		.pal_waddr  (pal_waddr),
		.pal_wdata  (pal_wdata)
	);

	video_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) timing0 (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.video_mode (video_mode),
		.pixel_x    (pixel_x),
		.pixel_y    (pixel_y),
		.de         (de),
		.hs         (tim_hs),
		.vs         (tim_vs),
		.irq_hsync  (irq_hsync),
		.irq_vsync  (irq_vsync),
		.frame_tick (frame_tick)
	);

	// Sync leaves through the mixer so it stays with the pixel
	pixel_mixer mixer0 (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.sprite_index (sprite_index),
		.bg_index     (bg_index),
		.de           (de),
		.hs           (tim_hs),
		.vs           (tim_vs),
		.bg_color     (bg_color),
		.pal_rdata    (pal_rdata),
		.pal_raddr    (pal_raddr),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.hs_out       (hs),
		.vs_out       (vs)
	);

	palette_ram pal0 (
		.CLK   (CLK),
		.we    (pal_we),
		.waddr (pal_waddr),
		.raddr (pal_raddr),
		.wdata (pal_wdata),
		.rdata (pal_rdata)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 4
)
(
	output logic CLK
);

	initial
	begin
		CLK = 1'b0;
		forever
			#(PERIOD_NS / 2.0) CLK = ~CLK;
	end

endmodule

`default_nettype wire

// File: sim/gfx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_tb;

	localparam int CLK_PERIOD_NS = 4;
	localparam int H_ACT = 16;
	localparam int H_FP  = 2;
	localparam int H_SW  = 3;
	localparam int H_BP  = 3;
	localparam int V_ACT = 8;
	localparam int V_FP  = 1;
	localparam int V_SW  = 2;
	localparam int V_BP  = 1;
	localparam int H_TOTAL = H_ACT + H_FP + H_SW + H_BP;
	localparam int V_TOTAL = V_ACT + V_FP + V_SW + V_BP;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int CAPTURE_LEN = 2 * FRAME_CYCLES;
	// Twelve frames cover every test plus one frame of slack
	localparam int WATCHDOG_CYCLES = 13 * FRAME_CYCLES;

	logic CLK;
	logic RSTb;
	logic psel;
	logic penable;
	logic pwrite;
	gfx_pkg::apb_addr_t paddr;
	gfx_pkg::apb_data_t pwdata;
	gfx_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	gfx_pkg::coord_t pixel_x;
	gfx_pkg::coord_t pixel_y;
	gfx_pkg::color_index_t sprite_index;
	gfx_pkg::color_index_t bg_index;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic hs;
	logic vs;
	logic de;
	logic irq_hsync;
	logic irq_vsync;

	integer seed;
	int errors;
	int checks;
	int tests_run;

	// Reference raster counters and the line seen by the last read
	gfx_pkg::coord_t model_h;
	gfx_pkg::coord_t model_v;
	gfx_pkg::coord_t read_line;

	gfx_pkg::color_t pal_model [0:255];
	logic hs_log [0:CAPTURE_LEN-1];
	logic vs_log [0:CAPTURE_LEN-1];
	logic irqh_log [0:CAPTURE_LEN-1];
	logic irqv_log [0:CAPTURE_LEN-1];

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clk0 (.CLK(CLK));

	gfx_top #(
		.H_ACTIVE (H_ACT),
		.H_FRONT  (H_FP),
		.H_SYNC   (H_SW),
		.H_BACK   (H_BP),
		.V_ACTIVE (V_ACT),
		.V_FRONT  (V_FP),
		.V_SYNC   (V_SW),
		.V_BACK   (V_BP)
	) dut0 (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.sprite_index (sprite_index),
		.bg_index     (bg_index),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.hs           (hs),
		.vs           (vs),
		.de           (de),
		.irq_hsync    (irq_hsync),
		.irq_vsync    (irq_vsync)
	);

	// Counters restart at zero on reset release
	always @(posedge CLK)
	begin
		if (!RSTb)
		begin
			model_h <= '0;
			model_v <= '0;
		end
		else if (model_h == gfx_pkg::coord_t'(H_TOTAL - 1))
		begin
			model_h <= '0;
			model_v <= (model_v == gfx_pkg::coord_t'(V_TOTAL - 1)) ? '0 : model_v + 10'd1;
		end
		else
			model_h <= model_h + 10'd1;
	end

	task automatic compare_color(input gfx_pkg::color_t got, input gfx_pkg::color_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_word(input gfx_pkg::apb_data_t got, input gfx_pkg::apb_data_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic apb_write(input gfx_pkg::apb_addr_t addr, input gfx_pkg::apb_data_t data,
		input logic exp_err);
		@(posedge CLK);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge CLK);
		penable <= 1'b1;
		@(negedge CLK);
		compare_bit(pready, 1'b1, "pready in write access");
		compare_bit(pslverr, exp_err, "pslverr in write access");
		@(posedge CLK);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input gfx_pkg::apb_addr_t addr, input logic exp_err,
		output gfx_pkg::apb_data_t data);
		@(posedge CLK);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge CLK);
		penable <= 1'b1;
		@(negedge CLK);
		data = prdata;
		read_line = model_v;
		compare_bit(pready, 1'b1, "pready in read access");
		compare_bit(pslverr, exp_err, "pslverr in read access");
		@(posedge CLK);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic expect_read(input gfx_pkg::apb_addr_t addr, input gfx_pkg::apb_data_t exp,
		input string what);
		gfx_pkg::apb_data_t data;
		apb_read(addr, 1'b0, data);
		compare_word(data, exp, what);
	endtask

	task automatic wait_for_vsync_irq();
		int n;
		n = 0;
		do
		begin
			@(negedge CLK);
			n++;
		end
		while (!irq_vsync && n < 2 * FRAME_CYCLES);
		if (!irq_vsync)
		begin
			errors++;
			$display("irq_vsync did not pulse within two frames at %0t", $time);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("%s: passed", name);
		else
			$display("%s: failed with %0d errors", name, errors - errs_before);
	endtask

	// Distinct colour for every palette entry
	function automatic gfx_pkg::color_t fill_color(input int idx);
		return gfx_pkg::color_t'((idx * 12'h2B5) ^ 12'h3C7);
	endfunction

	// Sprite wins over background unless its low nibble is zero
	function automatic gfx_pkg::color_t expected_pixel(input logic de_now,
		input gfx_pkg::color_index_t spr, input gfx_pkg::color_index_t bgi,
		input gfx_pkg::color_t bgc);
		if (!de_now)
			return '0;
		if (spr[3:0] != 4'h0)
			return pal_model[spr];
		if (bgi[3:0] != 4'h0)
			return pal_model[bgi];
		return bgc;
	endfunction

	task automatic test_registers();
		int errs_before;
		errs_before = errors;
		expect_read(gfx_pkg::REG_FRAME_COUNT, 16'h0000, "frame count after reset");
		expect_read(gfx_pkg::REG_VIDEO_MODE, 16'h0000, "mode after reset");
		expect_read(gfx_pkg::REG_BG_COLOR, 16'h0000, "bg colour after reset");
		apb_write(gfx_pkg::REG_VIDEO_MODE, 16'hFFFF, 1'b0);
		expect_read(gfx_pkg::REG_VIDEO_MODE, 16'h0001, "mode masked to one bit");
		apb_write(gfx_pkg::REG_VIDEO_MODE, 16'h0000, 1'b0);
		expect_read(gfx_pkg::REG_VIDEO_MODE, 16'h0000, "mode cleared");
		apb_write(gfx_pkg::REG_BG_COLOR, 16'hABCD, 1'b0);
		expect_read(gfx_pkg::REG_BG_COLOR, 16'h0BCD, "bg colour masked to 12 bits");
		report_test("registers", errs_before);
	endtask

	task automatic test_errors();
		int errs_before;
		gfx_pkg::apb_data_t data;
		errs_before = errors;
		apb_write(gfx_pkg::REG_FRAME_COUNT, 16'h5A5A, 1'b1);
		apb_write(gfx_pkg::REG_DISPLAY_Y, 16'h0007, 1'b1);
		apb_read(12'hE10, 1'b1, data);
		apb_write(12'h800, 16'h0FFF, 1'b1);
		apb_read(12'h800, 1'b1, data);
		// Still well inside the first frame
		expect_read(gfx_pkg::REG_FRAME_COUNT, 16'h0000, "frame count after bad write");
		expect_read(gfx_pkg::REG_VIDEO_MODE, 16'h0000, "mode after bad accesses");
		expect_read(gfx_pkg::REG_BG_COLOR, 16'h0BCD, "bg colour after bad accesses");
		report_test("error responses", errs_before);
	endtask

	task automatic test_timing();
		int errs_before;
		int i;
		int j;
		int last_fall;
		int irqh_count;
		int irqv_count;
		logic vs_seen;
		gfx_pkg::apb_data_t f_before;
		gfx_pkg::apb_data_t f_after;
		gfx_pkg::apb_data_t line;
		errs_before = errors;
		for (i = 0; i < CAPTURE_LEN; i++)
		begin
			@(negedge CLK);
			hs_log[i] = hs;
			vs_log[i] = vs;
			irqh_log[i] = irq_hsync;
			irqv_log[i] = irq_vsync;
		end
		last_fall = -1;
		vs_seen = 1'b0;
		for (i = 1; i < CAPTURE_LEN; i++)
		begin
			if (hs_log[i - 1] && !hs_log[i])
			begin
				if (last_fall >= 0)
					compare_word(16'(i - last_fall), 16'(H_TOTAL), "hs period");
				last_fall = i;
				j = i;
				while (j < CAPTURE_LEN && !hs_log[j])
					j++;
				if (j < CAPTURE_LEN)
					compare_word(16'(j - i), 16'(H_SW), "hs low phase");
			end
			if (vs_log[i - 1] && !vs_log[i])
			begin
				j = i;
				while (j < CAPTURE_LEN && !vs_log[j])
					j++;
				if (j < CAPTURE_LEN)
				begin
					vs_seen = 1'b1;
					compare_word(16'(j - i), 16'(V_SW * H_TOTAL), "vs low phase");
				end
			end
			if (irqh_log[i - 1])
				compare_bit(irqh_log[i], 1'b0, "irq_hsync lasting one cycle");
		end
		if (!vs_seen)
		begin
			errors++;
			$display("no complete vs low phase seen in two frames at %0t", $time);
		end
		irqh_count = 0;
		irqv_count = 0;
		for (i = 0; i < FRAME_CYCLES; i++)
		begin
			irqh_count += int'(irqh_log[i]);
			irqv_count += int'(irqv_log[i]);
		end
		compare_word(16'(irqh_count), 16'(V_TOTAL), "irq_hsync pulses per frame");
		compare_word(16'(irqv_count), 16'd1, "irq_vsync pulses per frame");

		// Three frame ticks fall between these two reads
		wait_for_vsync_irq();
		apb_read(gfx_pkg::REG_FRAME_COUNT, 1'b0, f_before);
		repeat (3)
			wait_for_vsync_irq();
		apb_read(gfx_pkg::REG_FRAME_COUNT, 1'b0, f_after);
		compare_word(f_after - f_before, 16'd3, "frame count growth over 3 frames");
		apb_read(gfx_pkg::REG_DISPLAY_Y, 1'b0, line);
		compare_word(line, 16'(read_line), "display line readback");
		report_test("raster timing", errs_before);
	endtask

	task automatic test_composition();
		int errs_before;
		int i;
		int n;
		logic [31:0] r;
		logic de_exp;
		gfx_pkg::color_index_t spr;
		gfx_pkg::color_index_t bgi;
		gfx_pkg::color_t bgc;
		gfx_pkg::color_t exp_q [$];
		errs_before = errors;
		bgc = 12'h5A3;
		apb_write(gfx_pkg::REG_BG_COLOR, 16'(bgc), 1'b0);
		for (i = 0; i < 256; i++)
		begin
			pal_model[i] = fill_color(i);
			apb_write(gfx_pkg::PALETTE_BASE + 12'(i), 16'(pal_model[i]), 1'b0);
		end
		for (n = 0; n < FRAME_CYCLES + 12; n++)
		begin
			r = $random(seed);
			spr = r[7:0];
			bgi = r[17:10];
			// Quarter of the indices made transparent
			if (r[9:8] == 2'b00)
				spr[3:0] = 4'h0;
			if (r[19:18] == 2'b00)
				bgi[3:0] = 4'h0;
			@(posedge CLK);
			sprite_index <= spr;
			bg_index     <= bgi;
			@(negedge CLK);
			// Active window from the reference counters
			de_exp = (model_h < gfx_pkg::coord_t'(H_ACT))
				&& (model_v < gfx_pkg::coord_t'(V_ACT));
			compare_bit(de, de_exp, "de window");
			compare_word(16'(pixel_x), 16'(model_h), "pixel_x in full resolution");
			compare_word(16'(pixel_y), 16'(model_v), "pixel_y in full resolution");
			exp_q.push_back(expected_pixel(de_exp, spr, bgi, bgc));
			if (n >= 2)
				compare_color({red, green, blue}, exp_q.pop_front(), "mixed pixel");
		end
		@(posedge CLK);
		sprite_index <= '0;
		bg_index     <= '0;
		report_test("composition", errs_before);
	endtask

	task automatic test_half_res();
		int errs_before;
		int n;
		gfx_pkg::apb_data_t line;
		errs_before = errors;
		apb_write(gfx_pkg::REG_VIDEO_MODE, 16'h0001, 1'b0);
		for (n = 0; n < FRAME_CYCLES + 12; n++)
		begin
			@(negedge CLK);
			compare_word(16'(pixel_x), 16'(model_h >> 1), "pixel_x in half resolution");
			compare_word(16'(pixel_y), 16'(model_v >> 1), "pixel_y in half resolution");
		end
		apb_read(gfx_pkg::REG_DISPLAY_Y, 1'b0, line);
		compare_word(line, 16'(read_line >> 1), "halved display line readback");
		apb_write(gfx_pkg::REG_VIDEO_MODE, 16'h0000, 1'b0);
		report_test("half resolution", errs_before);
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		$display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		seed = 32'he7c0_9273;
		errors = 0;
		checks = 0;
		tests_run = 0;
		RSTb         <= 1'b0;
		psel         <= 1'b0;
		penable      <= 1'b0;
		pwrite       <= 1'b0;
		paddr        <= '0;
		pwdata       <= '0;
		sprite_index <= '0;
		bg_index     <= '0;
		repeat (8)
			@(posedge CLK);
		RSTb <= 1'b1;

		test_registers();
		test_errors();
		test_timing();
		test_composition();
		test_half_res();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
rtl/gfx_pkg.sv
rtl/video_timing.sv
rtl/gfx_regs.sv
rtl/palette_ram.sv
rtl/pixel_mixer.sv
rtl/gfx_top.sv
sim/tb_clock.sv
sim/gfx_tb.sv

// File: Makefile
# Verilator build and run for the graphics display core

VERILATOR ?= verilator
TOP       ?= gfx_tb
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
